// ==== mem_subsys_top.f ====
+incdir+hw
hw/mem_pkg.sv
hw/wb_pkg.sv
hw/wb_lane_codec.sv
hw/mem_access_unit.sv
hw/wb_sram.sv
hw/mem_subsys_top.sv
tests/mem_subsys_sva.sv
tests/mem_subsys_tb.sv

// ==== tests/mem_subsys_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mem_config.svh"

module mem_subsys_tb;

  localparam int NUM_TESTS   = 17;
  localparam int LATENCY     = `MEM_RAM_WAIT + 2;
  localparam int CYCLE_LIMIT = NUM_TESTS * LATENCY * 8 + 50;
  localparam int HOLD_CYCLES = 6;   // grant kept low this long in the back-pressure case

  localparam logic [1:0] GRANT_RAND = 2'd0;
  localparam logic [1:0] GRANT_HIGH = 2'd1;  // fixed latency expected
  localparam logic [1:0] GRANT_HOLD = 2'd2;

  typedef struct packed {
    logic               write;
    mem_pkg::mem_size_e size;
    logic [31:0]        addr;
    logic [31:0]        wdata;
    logic               uns;
    logic [1:0]         mode;  // grant pattern during the access
  } test_vec_t;

  logic                 clk_i = 1'b0;
  logic                 rst_n_i;
  logic                 req_valid_i;
  mem_pkg::mem_req_t    req_i;
  logic                 busy_o;
  logic [`MEM_XLEN-1:0] rdata_o;
  logic                 err_o;
  logic                 bus_req_o;
  logic                 bus_grant_i;

  test_vec_t   vectors [NUM_TESTS];
  logic [7:0]  model_mem [`MEM_RAM_WORDS*4];  // byte-wise reference memory
  logic [31:0] last_rdata;
  int          cycle_cnt = 0;

  mem_subsys_top DUT (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .busy_o      (busy_o),
    .rdata_o     (rdata_o),
    .err_o       (err_o),
    .bus_req_o   (bus_req_o),
    .bus_grant_i (bus_grant_i)
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: no completion within %0d cycles", CYCLE_LIMIT);
      $display("Test failed");
      $fatal(1, "simulation stopped on timeout");
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic set_entry(input int idx, input logic write, input mem_pkg::mem_size_e size,
                           input logic [31:0] addr, input logic [31:0] wdata,
                           input logic uns, input logic [1:0] mode);
    vectors[idx] = '{write: write, size: size, addr: addr, wdata: wdata, uns: uns, mode: mode};
  endtask

  function automatic logic addr_in_range(input logic [31:0] addr);
    return addr[31:2] < `MEM_RAM_WORDS;
  endfunction

  task automatic model_store(input test_vec_t v);
    int base;
    int half;
    base = int'(v.addr[31:2]) * 4;
    half = base + (v.addr[1] ? 2 : 0);
    case (v.size)
      mem_pkg::SIZE_BYTE: model_mem[base + int'(v.addr[1:0])] = v.wdata[7:0];
      mem_pkg::SIZE_HALF: begin
        model_mem[half]     = v.wdata[7:0];
        model_mem[half + 1] = v.wdata[15:8];
      end
      default: begin  // word ignores the low address bits
        for (int b = 0; b < 4; b++) begin
          model_mem[base + b] = v.wdata[8*b +: 8];
        end
      end
    endcase
  endtask

  function automatic logic [31:0] model_load(input test_vec_t v);
    int          base;
    int          half;
    logic [7:0]  bval;
    logic [15:0] hval;
    base = int'(v.addr[31:2]) * 4;
    half = base + (v.addr[1] ? 2 : 0);
    case (v.size)
      mem_pkg::SIZE_BYTE: begin
        bval = model_mem[base + int'(v.addr[1:0])];
        return v.uns ? {24'h0, bval} : {{24{bval[7]}}, bval};
      end
      mem_pkg::SIZE_HALF: begin
        hval = {model_mem[half + 1], model_mem[half]};
        return v.uns ? {16'h0, hval} : {{16{hval[15]}}, hval};
      end
      default: return {model_mem[base + 3], model_mem[base + 2],
                        model_mem[base + 1], model_mem[base]};
    endcase
  endfunction

  // one strobe and then a grant per cycle until busy drops
  // cycles counts the edges from the accepting edge to the one that drops busy
  task automatic run_access(input test_vec_t v, output int cycles);
    mem_pkg::mem_req_t req;
    logic              grant;
    logic              finished;
    req = '{addr: v.addr, wdata: v.wdata, size: v.size, write: v.write, unsigned_ld: v.uns};
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_i       <= req;
    @(posedge clk_i);  // accepting edge
    req_valid_i <= 1'b0;
    cycles   = 0;
    finished = 1'b0;
    while (!finished) begin
      case (v.mode)
        GRANT_HIGH: grant = 1'b1;
        GRANT_HOLD: grant = (cycles >= HOLD_CYCLES);
        default:    grant = ($urandom % 3) != 0;  // low about a third of the time
      endcase
      bus_grant_i <= grant;
      @(negedge clk_i);
      check_value("bus_req_o", bus_req_o, busy_o);
      if (v.mode == GRANT_HOLD && cycles < HOLD_CYCLES) begin
        check_value("busy_o", busy_o, 1'b1);
        check_value("err_o", err_o, 1'b0);
      end
      if (!busy_o) begin
        finished = 1'b1;
      end else begin
        cycles++;
        @(posedge clk_i);
      end
    end
  endtask

  initial begin
    int   cycles;
    logic exp_err;
    void'($urandom(32'h2cb9_cfef));
    rst_n_i     = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    bus_grant_i = 1'b0;
    last_rdata  = '0;
    for (int i = 0; i < `MEM_RAM_WORDS*4; i++) begin
      model_mem[i] = 8'h00;
    end
    set_entry(0,  1'b1, mem_pkg::SIZE_WORD, 32'h0000_0010, 32'hdead_beef, 1'b0, GRANT_HIGH);
    set_entry(1,  1'b0, mem_pkg::SIZE_WORD, 32'h0000_0010, 32'h0,         1'b0, GRANT_HIGH);
    set_entry(2,  1'b1, mem_pkg::SIZE_BYTE, 32'h0000_0020, 32'h0000_0011, 1'b0, GRANT_RAND);
    set_entry(3,  1'b1, mem_pkg::SIZE_BYTE, 32'h0000_0021, 32'h0000_0022, 1'b0, GRANT_RAND);
    set_entry(4,  1'b1, mem_pkg::SIZE_BYTE, 32'h0000_0022, 32'hffff_ff80, 1'b0, GRANT_RAND);
    set_entry(5,  1'b1, mem_pkg::SIZE_BYTE, 32'h0000_0023, 32'h0000_0044, 1'b0, GRANT_RAND);
    set_entry(6,  1'b0, mem_pkg::SIZE_WORD, 32'h0000_0020, 32'h0,         1'b0, GRANT_RAND);
    set_entry(7,  1'b0, mem_pkg::SIZE_BYTE, 32'h0000_0022, 32'h0,         1'b0, GRANT_RAND);
    set_entry(8,  1'b0, mem_pkg::SIZE_BYTE, 32'h0000_0022, 32'h0,         1'b1, GRANT_RAND);
    set_entry(9,  1'b1, mem_pkg::SIZE_HALF, 32'h0000_0032, 32'h0000_8000, 1'b0, GRANT_RAND);
    set_entry(10, 1'b1, mem_pkg::SIZE_HALF, 32'h0000_0030, 32'h5555_1234, 1'b0, GRANT_RAND);
    set_entry(11, 1'b0, mem_pkg::SIZE_WORD, 32'h0000_0030, 32'h0,         1'b0, GRANT_RAND);
    set_entry(12, 1'b0, mem_pkg::SIZE_HALF, 32'h0000_0032, 32'h0,         1'b0, GRANT_HIGH);
    set_entry(13, 1'b0, mem_pkg::SIZE_HALF, 32'h0000_0032, 32'h0,         1'b1, GRANT_HOLD);
    set_entry(14, 1'b1, mem_pkg::SIZE_WORD, 32'h0000_0100, 32'hcafe_f00d, 1'b0, GRANT_RAND);
    set_entry(15, 1'b0, mem_pkg::SIZE_WORD, 32'h0000_0000, 32'h0,         1'b0, GRANT_RAND);
    set_entry(16, 1'b0, mem_pkg::SIZE_BYTE, 32'h0000_0105, 32'h0,         1'b0, GRANT_HIGH);

    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_value("busy_o", busy_o, 1'b0);
    check_value("err_o", err_o, 1'b0);
    check_value("bus_req_o", bus_req_o, 1'b0);
    check_value("rdata_o", rdata_o, 32'h0);

    for (int i = 0; i < NUM_TESTS; i++) begin
      run_access(vectors[i], cycles);
      exp_err = ~addr_in_range(vectors[i].addr);
      if (!exp_err) begin
        if (vectors[i].write) begin
          model_store(vectors[i]);
        end else begin
          last_rdata = model_load(vectors[i]);
        end
      end
      check_value("err_o", err_o, exp_err);
      check_value("rdata_o", rdata_o, last_rdata);  // stores and errors keep the old value
      if (vectors[i].mode == GRANT_HIGH) begin
        check_value("latency", cycles, LATENCY);
      end
    end

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/mem_subsys_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mem_config.svh"

module mem_subsys_sva (
  input logic            clk_i,
  input logic            rst_n_i,
  input logic            req_valid_i,
  input logic            busy_o,
  input logic            bus_grant_i,
  input wb_pkg::wb_m2s_t wb_o,
  input wb_pkg::wb_s2m_t wb_i
);

  logic done;

  assign done = bus_grant_i & (wb_i.ack | wb_i.err);

  a_reset_idle: assert property (@(posedge clk_i) !rst_n_i |=> !busy_o)
    else $error("busy_o high in the cycle after reset");

  a_strb_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_o.cyc_stb && !done |=> wb_o.cyc_stb)
    else $error("cyc_stb dropped before a granted ack or err");

  a_strb_drop: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_o.cyc_stb && done |=> !wb_o.cyc_stb)
    else $error("cyc_stb still high after a granted ack or err");

  a_sel_nonzero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_o.cyc_stb |-> wb_o.sel != '0)
    else $error("byte select is zero during a bus cycle");

  a_no_req_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    busy_o |-> !req_valid_i)
    else $error("request strobe while the unit is busy");

  // slave holds off its answer for the wait states
  a_wait_states: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(wb_o.cyc_stb) |-> !(wb_i.ack || wb_i.err) [* `MEM_RAM_WAIT + 1])
    else $error("slave answered before its wait states");

endmodule

bind mem_access_unit mem_subsys_sva u_sva (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .req_valid_i (req_valid_i),
  .busy_o      (busy_o),
  .bus_grant_i (bus_grant_i),
  .wb_o        (wb_o),
  .wb_i        (wb_i)
);

`default_nettype wire

// ==== hw/mem_subsys_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mem_config.svh"

module mem_subsys_top (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 req_valid_i,
  input  mem_pkg::mem_req_t    req_i,
  output logic                 busy_o,
  output logic [`MEM_XLEN-1:0] rdata_o,
  output logic                 err_o,
  output logic                 bus_req_o,
  input  logic                 bus_grant_i  // external arbiter
);

  wb_pkg::wb_m2s_t wb_m2s;
  wb_pkg::wb_s2m_t wb_s2m;

  // bus master on the core side
  mem_access_unit u_access (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .busy_o      (busy_o),
    .rdata_o     (rdata_o),
    .err_o       (err_o),
    .wb_o        (wb_m2s),
    .wb_i        (wb_s2m),
    .bus_req_o   (bus_req_o),
    .bus_grant_i (bus_grant_i)
  );

  wb_sram u_sram (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .wb_i    (wb_m2s),
    .wb_o    (wb_s2m)
  );

endmodule

`default_nettype wire

// ==== hw/wb_sram.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mem_config.svh"

module wb_sram (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  wb_pkg::wb_m2s_t wb_i,
  output wb_pkg::wb_s2m_t wb_o
);

  localparam int IDX_W = $clog2(`MEM_RAM_WORDS);
  localparam int CNT_W = $clog2(`MEM_RAM_WAIT + 2);

  logic [`MEM_XLEN-1:0] mem [`MEM_RAM_WORDS];
  logic [`MEM_XLEN-1:0] dat_q;
  logic                 ack_q;
  logic                 err_q;
  logic [CNT_W-1:0]     cnt_q;  // wait cycles seen so far
  logic                 fire;
  logic                 in_range;
  logic [IDX_W-1:0]     idx;

  initial begin
    for (int i = 0; i < `MEM_RAM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  // no new answer while the last ack or err is still on the bus
  assign fire     = wb_i.cyc_stb & ~ack_q & ~err_q & (cnt_q == CNT_W'(`MEM_RAM_WAIT));
  assign in_range = wb_i.adr < (`MEM_XLEN-2)'(`MEM_RAM_WORDS);
  assign idx      = wb_i.adr[IDX_W-1:0];

  assign wb_o = '{dat: dat_q, ack: ack_q, err: err_q};

  always_ff @(posedge clk_i) begin
    if (fire && in_range) begin
      dat_q <= mem[idx]; // word as it was before this cycle's write
      if (wb_i.we) begin
        for (int b = 0; b < `MEM_XLEN/8; b++) begin
          if (wb_i.sel[b]) mem[idx][8*b +: 8] <= wb_i.dat[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
      cnt_q <= '0;
    end else begin
      ack_q <= fire & in_range;   // one-cycle pulses
      err_q <= fire & ~in_range;
      if (fire || !wb_i.cyc_stb) begin
        cnt_q <= '0;
      end else if (!ack_q && !err_q) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/mem_access_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mem_config.svh"

module mem_access_unit (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 req_valid_i,
  input  mem_pkg::mem_req_t    req_i,
  output logic                 busy_o,
  output logic [`MEM_XLEN-1:0] rdata_o,
  output logic                 err_o,
  output wb_pkg::wb_m2s_t      wb_o,
  input  wb_pkg::wb_s2m_t      wb_i,
  output logic                 bus_req_o,
  input  logic                 bus_grant_i
);

  typedef enum logic {
    IDLE,
    BUS
  } state_e;

  state_e                 state_q;
  wb_pkg::wb_m2s_t        wb_q;
  mem_pkg::mem_size_e     size_q;  // kept for the load decode
  logic [1:0]             off_q;
  logic                   uns_q;
  logic [`MEM_XLEN/8-1:0] st_sel;
  logic [`MEM_XLEN-1:0]   st_lanes;
  logic [`MEM_XLEN-1:0]   ld_data;
  logic                   done;

  // store side, straight from the incoming request
  wb_lane_codec u_st_codec (
    .size_i     (req_i.size),
    .byte_off_i (req_i.addr[1:0]),
    .unsigned_i (req_i.unsigned_ld),
    .store_i    (req_i.wdata),
    .lanes_i    ('0),
    .sel_o      (st_sel),
    .lanes_o    (st_lanes),
    .load_o     ()
  );

  // load side, from the registered request and the bus data
  wb_lane_codec u_ld_codec (
    .size_i     (size_q),
    .byte_off_i (off_q),
    .unsigned_i (uns_q),
    .store_i    ('0),
    .lanes_i    (wb_i.dat),
    .sel_o      (),
    .lanes_o    (),
    .load_o     (ld_data)
  );

  assign done = bus_grant_i & (wb_i.ack | wb_i.err); // slave answer only counts with grant
  assign wb_o = wb_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q      <= IDLE;
      busy_o       <= 1'b0;
      bus_req_o    <= 1'b0;
      err_o        <= 1'b0;
      rdata_o      <= '0;
      wb_q.cyc_stb <= 1'b0;
      wb_q.we      <= 1'b0;
      wb_q.sel     <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (req_valid_i) begin
            state_q      <= BUS;
            busy_o       <= 1'b1;
            bus_req_o    <= 1'b1;
            err_o        <= 1'b0; // a new request clears the old error
            wb_q.adr     <= req_i.addr[`MEM_XLEN-1:2];
            wb_q.dat     <= st_lanes;
            wb_q.sel     <= st_sel;
            wb_q.we      <= req_i.write;
            wb_q.cyc_stb <= 1'b1;
            size_q       <= req_i.size;
            off_q        <= req_i.addr[1:0];
            uns_q        <= req_i.unsigned_ld;
          end
        end
        BUS: begin
          // without grant strb stays up and the slave will answer again
          if (done) begin
            state_q      <= IDLE;
            busy_o       <= 1'b0;
            bus_req_o    <= 1'b0;
            wb_q.cyc_stb <= 1'b0;
            wb_q.we      <= 1'b0;
            if (wb_i.err) begin
              err_o <= 1'b1;
            end else if (!wb_q.we) begin
              rdata_o <= ld_data;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/wb_lane_codec.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mem_config.svh"

module wb_lane_codec (
  input  mem_pkg::mem_size_e     size_i,
  input  logic [1:0]             byte_off_i,
  input  logic                   unsigned_i,
  input  logic [`MEM_XLEN-1:0]   store_i,
  input  logic [`MEM_XLEN-1:0]   lanes_i,
  output logic [`MEM_XLEN/8-1:0] sel_o,
  output logic [`MEM_XLEN-1:0]   lanes_o,
  output logic [`MEM_XLEN-1:0]   load_o
);

  logic [`MEM_XLEN-1:0] shifted; // selected lanes moved down to bit 0
  logic                 sext;

  assign sext = ~unsigned_i;

  always_comb begin
    case (size_i)
      mem_pkg::SIZE_BYTE: begin
        sel_o   = 4'b0001 << byte_off_i;
        lanes_o = {(`MEM_XLEN/8){store_i[7:0]}}; // same byte on every lane
        shifted = lanes_i >> {byte_off_i, 3'b000};
        load_o  = {{(`MEM_XLEN-8){sext & shifted[7]}}, shifted[7:0]};
      end
      mem_pkg::SIZE_HALF: begin
        // only bit 1 of the offset matters, misalignment is not trapped
        sel_o   = byte_off_i[1] ? 4'b1100 : 4'b0011;
        lanes_o = {(`MEM_XLEN/16){store_i[15:0]}};
        shifted = lanes_i >> {byte_off_i[1], 4'b0000};
        load_o  = {{(`MEM_XLEN-16){sext & shifted[15]}}, shifted[15:0]};
      end
      default: begin // word, low address bits ignored
        sel_o   = 4'b1111;
        lanes_o = store_i;
        shifted = lanes_i;
        load_o  = shifted;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/wb_pkg.sv ====
`default_nettype none

`include "mem_config.svh"

package wb_pkg;

  // master to slave, classic cycle with cyc and stb merged
  typedef struct packed {
    logic [`MEM_XLEN-3:0]   adr;     // word address
    logic [`MEM_XLEN-1:0]   dat;
    logic [`MEM_XLEN/8-1:0] sel;     // byte lanes
    logic                   cyc_stb;
    logic                   we;
  } wb_m2s_t;

  // slave to master
  typedef struct packed {
    logic [`MEM_XLEN-1:0] dat;
    logic                 ack;
    logic                 err;
  } wb_s2m_t;

endpackage

`default_nettype wire

// ==== hw/mem_pkg.sv ====
`default_nettype none

`include "mem_config.svh"

package mem_pkg;

  // access width of a load or store
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } mem_size_e;

  // one request from the core, valid with the strobe
  typedef struct packed {
    logic [`MEM_XLEN-1:0] addr;   // byte address
    logic [`MEM_XLEN-1:0] wdata;  // store data, right aligned
    mem_size_e            size;
    logic                 write;
    logic                 unsigned_ld; // zero-extend on load
  } mem_req_t;

endpackage

`default_nettype wire

// ==== hw/mem_config.svh ====
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// data and address width of the core
`define MEM_XLEN 32

// ram size in 32-bit words, word addresses at or above this answer err
`define MEM_RAM_WORDS 64

// cycles the ram holds off ack once it sees strb
`define MEM_RAM_WAIT 1

`endif
